// ==== logic/cfg_pkg.sv ====
/*
  Shared widths, word types and record layout of the configuration loader.
  Word positions assume a fixed sequence of seq_len setup words per engine.
*/
package cfg_pkg;

    // ------------------------------------------------------------------
    // Widths and plain word types
    // ------------------------------------------------------------------
    localparam int data_w  = 32;
    localparam int index_w = 8;

    typedef logic [data_w-1:0]  cfg_word_t;
    typedef logic [index_w-1:0] word_index_t;

    // Buffer class carried by every memory response
    typedef enum logic [2:0] {
        class_none         = 3'd0,
        class_cu_setup     = 3'd1,
        class_engine_setup = 3'd2,
        class_data         = 3'd3,
        class_other        = 3'd4
    } buffer_class_e;

    typedef struct packed {
        buffer_class_e buffer_class;
        word_index_t   word_index;
        cfg_word_t     data;
    } setup_word_t;

    // ------------------------------------------------------------------
    // Assembled configuration record
    // ------------------------------------------------------------------
    typedef struct packed {
        logic                    increment;
        logic                    decrement;
        logic                    mode_sequence;
        logic                    mode_buffer;
        logic                    mode_counter;
        cfg_word_t               index_start;
        cfg_word_t               index_end;
        cfg_word_t               stride;
        logic [data_w-2:0]       granularity;
        logic                    direction;
        logic [2*data_w-1:0]     array_pointer;
        cfg_word_t               array_size;
    } engine_config_t;

    // Word positions inside one setup sequence
    localparam int seq_len         = 8;
    localparam int pos_flags       = 0;
    localparam int pos_index_start = 1;
    localparam int pos_index_end   = 2;
    localparam int pos_stride      = 3;
    localparam int pos_granularity = 4;
    localparam int pos_pointer_lo  = 5;
    localparam int pos_pointer_hi  = 6;
    localparam int pos_array_size  = 7;

endpackage

// ==== logic/setup_filter.sv ====
/*
  Window base is engine_slot * seq_len and must fit in word_index_t.
  One cycle of latency from resp_valid to push, no back-pressure.
*/
`timescale 1ns/1ps

module setup_filter #(
    parameter int engine_slot = 0
) (
    input  logic                ap_clk,
    input  logic                rst,
    input  logic                resp_valid,
    input  cfg_pkg::setup_word_t resp_word,
    output logic                push,
    output cfg_pkg::setup_word_t push_word
);

    import cfg_pkg::*;

    // Window of word indexes owned by this engine
    localparam word_index_t win_base = word_index_t'(engine_slot * seq_len);
    localparam word_index_t win_last = word_index_t'(engine_slot * seq_len + seq_len - 1);

    logic        resp_valid_reg;
    setup_word_t resp_word_reg;
    logic        is_setup;
    logic        in_window;

    // ------------------------------------------------------------------
    // Input register
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (rst) begin
            resp_valid_reg <= 1'b0;
        end else begin
            resp_valid_reg <= resp_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        resp_word_reg <= resp_word;
    end

    // ------------------------------------------------------------------
    // Class and window filter
    // ------------------------------------------------------------------
    always_comb begin
        is_setup  = (resp_word_reg.buffer_class == class_cu_setup) ||
                    (resp_word_reg.buffer_class == class_engine_setup);
        in_window = (resp_word_reg.word_index >= win_base) &&
                    (resp_word_reg.word_index <= win_last);
    end

    assign push      = resp_valid_reg & is_setup & in_window;
    assign push_word = resp_word_reg;

endmodule

// ==== logic/sync_fifo.sv ====
/*
  fifo_depth must be a power of two, at least 2. Read data is valid one
  cycle after pop. A push while full is lost and latches overflow until reset.
*/
`timescale 1ns/1ps

module sync_fifo #(
    parameter int fifo_depth = 16
) (
    input  logic                 ap_clk,
    input  logic                 rst,
    input  logic                 push,
    input  cfg_pkg::setup_word_t push_word,
    input  logic                 pop,
    output logic                 pop_valid,
    output cfg_pkg::setup_word_t pop_word,
    output logic                 not_empty,
    output logic                 overflow
);

    import cfg_pkg::*;

    localparam int addr_w = $clog2(fifo_depth);

    typedef logic [addr_w-1:0] fifo_addr_t;
    typedef logic [addr_w:0]   fifo_count_t;

    localparam fifo_count_t full_count = fifo_count_t'(fifo_depth);

    setup_word_t mem [fifo_depth];
    fifo_addr_t  wr_ptr;
    fifo_addr_t  rd_ptr;
    fifo_count_t count;
    logic        full;
    logic        do_push;
    logic        do_pop;

    assign full      = (count == full_count);
    assign not_empty = (count != '0);
    assign do_push   = push & ~full;
    assign do_pop    = pop & not_empty;

    // ------------------------------------------------------------------
    // Pointers, occupancy and overflow
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            pop_valid <= 1'b0;
            overflow  <= 1'b0;
        end else begin
            pop_valid <= do_pop;
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Net occupancy change
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
            if (push && full) begin
                overflow <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // Storage and registered read port
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_word;
        end
        if (do_pop) begin
            pop_word <= mem[rd_ptr];
        end
    end

endmodule

// ==== logic/config_assembler.sv ====
/*
  A sequence starts only on the window base index; later words fill positions
  in arrival order whatever their index. config_out holds between records.
*/
`timescale 1ns/1ps

module config_assembler #(
    parameter int engine_slot = 0
) (
    input  logic                    ap_clk,
    input  logic                    rst,
    input  logic                    drain_en,
    input  logic                    not_empty,
    output logic                    pop,
    input  logic                    pop_valid,
    input  cfg_pkg::setup_word_t    pop_word,
    output logic                    config_valid,
    output cfg_pkg::engine_config_t config_out
);

    import cfg_pkg::*;

    typedef logic [$clog2(seq_len)-1:0] seq_pos_t;

    typedef enum logic [1:0] {
        st_idle,
        st_collect,
        st_emit
    } assembler_state_e;

    localparam word_index_t win_base = word_index_t'(engine_slot * seq_len);

    assembler_state_e state;
    seq_pos_t         pos_cnt;
    seq_pos_t         wr_pos;
    logic             start_hit;
    logic             wr_en;
    cfg_word_t        data;

    // Words landing in emit are judged like words in idle
    assign start_hit = pop_valid && (state != st_collect) &&
                       (pop_word.word_index == win_base);
    assign wr_en     = start_hit || (pop_valid && (state == st_collect));
    assign wr_pos    = (state == st_collect) ? pos_cnt : seq_pos_t'(pos_flags);
    assign data      = pop_word.data;

    assign pop          = not_empty & drain_en & (state != st_emit);
    assign config_valid = (state == st_emit);

    // ------------------------------------------------------------------
    // Sequence FSM
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (rst) begin
            state   <= st_idle;
            pos_cnt <= '0;
        end else begin
            case (state)
                st_collect: begin
                    if (pop_valid) begin
                        if (pos_cnt == seq_pos_t'(pos_array_size)) begin
                            state <= st_emit;
                        end else begin
                            pos_cnt <= pos_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    // idle and emit
                    if (start_hit) begin
                        state   <= st_collect;
                        pos_cnt <= seq_pos_t'(pos_index_start);
                    end else begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    // ------------------------------------------------------------------
    // Positional field capture
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            case (wr_pos)
                pos_flags: begin
                    config_out.increment     <= data[0];
                    config_out.decrement     <= data[1];
                    config_out.mode_sequence <= data[2];
                    config_out.mode_buffer   <= data[3];
                    config_out.mode_counter  <= data[4];
                end
                pos_index_start: config_out.index_start <= data;
                pos_index_end:   config_out.index_end   <= data;
                pos_stride:      config_out.stride      <= data;
                pos_granularity: begin
                    config_out.granularity <= data[data_w-2:0];
                    config_out.direction   <= data[data_w-1];
                end
                pos_pointer_lo:  config_out.array_pointer[data_w-1:0]        <= data;
                pos_pointer_hi:  config_out.array_pointer[2*data_w-1:data_w] <= data;
                pos_array_size:  config_out.array_size  <= data;
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== logic/engine_config_loader.sv ====
/*
  Latency to config_valid depends on drain_en and FIFO occupancy.
  overflow stays high from the first lost push until reset.
*/
`timescale 1ns/1ps

module engine_config_loader #(
    parameter int engine_slot = 0,
    parameter int fifo_depth  = 16
) (
    input  logic                    ap_clk,
    input  logic                    rst,
    input  logic                    resp_valid,
    input  cfg_pkg::setup_word_t    resp_word,
    input  logic                    drain_en,
    output logic                    config_valid,
    output cfg_pkg::engine_config_t config_out,
    output logic                    overflow
);

    import cfg_pkg::*;

    // ------------------------------------------------------------------
    // Internal links
    // ------------------------------------------------------------------
    logic        push;
    setup_word_t push_word;
    logic        pop;
    logic        pop_valid;
    setup_word_t pop_word;
    logic        not_empty;

    // Producer
    setup_filter #(
        .engine_slot(engine_slot)
    ) i_setup_filter (
        .ap_clk    (ap_clk),
        .rst       (rst),
        .resp_valid(resp_valid),
        .resp_word (resp_word),
        .push      (push),
        .push_word (push_word)
    );

    // Response buffer
    sync_fifo #(
        .fifo_depth(fifo_depth)
    ) i_sync_fifo (
        .ap_clk   (ap_clk),
        .rst      (rst),
        .push     (push),
        .push_word(push_word),
        .pop      (pop),
        .pop_valid(pop_valid),
        .pop_word (pop_word),
        .not_empty(not_empty),
        .overflow (overflow)
    );

    // Consumer
    config_assembler #(
        .engine_slot(engine_slot)
    ) i_config_assembler (
        .ap_clk      (ap_clk),
        .rst         (rst),
        .drain_en    (drain_en),
        .not_empty   (not_empty),
        .pop         (pop),
        .pop_valid   (pop_valid),
        .pop_word    (pop_word),
        .config_valid(config_valid),
        .config_out  (config_out)
    );

endmodule

// ==== sim/config_checker.sv ====
/*
  Reference model of the loader, stepped on rising edges from the DUT inputs.
  Outputs are compared on falling edges, config_out only while a record is due.
*/
`timescale 1ns/1ps

module config_checker #(
    parameter int engine_slot = 0,
    parameter int fifo_depth  = 16
) (
    input  logic                    ap_clk,
    input  logic                    rst,
    input  logic                    resp_valid,
    input  cfg_pkg::setup_word_t    resp_word,
    input  logic                    drain_en,
    input  logic                    config_valid,
    input  cfg_pkg::engine_config_t config_out,
    input  logic                    overflow,
    input  int                      test_id,
    input  logic                    expect_rec,
    output int                      error_count
);

    import cfg_pkg::*;

    localparam int          seq_words = 8;
    localparam word_index_t base      = word_index_t'(engine_slot * seq_words);
    localparam word_index_t last      = word_index_t'(engine_slot * seq_words + seq_words - 1);

    setup_word_t    fifo_q [$];
    setup_word_t    f_word;
    setup_word_t    p_word;
    logic           f_valid;
    logic           p_valid;
    logic           collecting;
    logic           emit_now;
    logic           was_full;
    logic           do_pop;
    logic           exp_valid;
    logic           exp_overflow;
    engine_config_t exp_rec;
    int             seq_pos;
    int             row_test = 0;
    int             cur_test = 0;
    int             err_base = 0;
    int             exp_cnt [8] = '{default: 0};
    int             seen_cnt [8] = '{default: 0};

    initial error_count = 0;

    function automatic logic qualifies(setup_word_t w);
        logic setup_cls;
        setup_cls = (w.buffer_class == class_cu_setup) ||
                    (w.buffer_class == class_engine_setup);
        return setup_cls && (w.word_index >= base) && (w.word_index <= last);
    endfunction

    // Positional mapping of one sequence word into the record
    task automatic fill(input int pos, input cfg_word_t d);
        case (pos)
            0: begin
                exp_rec.increment     = d[0];
                exp_rec.decrement     = d[1];
                exp_rec.mode_sequence = d[2];
                exp_rec.mode_buffer   = d[3];
                exp_rec.mode_counter  = d[4];
            end
            1: exp_rec.index_start = d;
            2: exp_rec.index_end   = d;
            3: exp_rec.stride      = d;
            4: begin
                exp_rec.granularity = d[30:0];
                exp_rec.direction   = d[31];
            end
            5: exp_rec.array_pointer[31:0]  = d;
            6: exp_rec.array_pointer[63:32] = d;
            default: exp_rec.array_size = d;
        endcase
    endtask

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        if (got !== want) begin
            $display("ERROR %s: got %0h expected %0h", name, got, want);
            error_count++;
        end
    endtask

    task automatic report_test(input int t);
        if (seen_cnt[t] != exp_cnt[t]) begin
            $display("test %0d: %0d records seen where %0d were expected",
                     t, seen_cnt[t], exp_cnt[t]);
            error_count++;
        end
        $display("test %0d done: %0d records, %0d errors", t, seen_cnt[t],
                 error_count - err_base);
    endtask

    // ------------------------------------------------------------------
    // Model step
    // ------------------------------------------------------------------
    always @(posedge ap_clk) begin
        row_test = test_id;
        if (rst) begin
            f_valid      = 1'b0;
            p_valid      = 1'b0;
            collecting   = 1'b0;
            seq_pos      = 0;
            exp_valid    = 1'b0;
            exp_overflow = 1'b0;
            fifo_q.delete();
        end else begin
            if (expect_rec) begin
                exp_cnt[test_id]++;
            end
            emit_now  = exp_valid;
            exp_valid = 1'b0;
            // Word returned by the pop of the previous cycle
            if (p_valid && collecting) begin
                fill(seq_pos, p_word.data);
                if (seq_pos == seq_words - 1) begin
                    collecting = 1'b0;
                    exp_valid  = 1'b1;
                end else begin
                    seq_pos++;
                end
            end else if (p_valid && (p_word.word_index == base)) begin
                fill(0, p_word.data);
                collecting = 1'b1;
                seq_pos    = 1;
            end
            // Full is judged before this cycle's pop
            was_full = (fifo_q.size() == fifo_depth);
            do_pop   = (fifo_q.size() != 0) && drain_en && !emit_now;
            p_valid  = do_pop;
            if (do_pop) begin
                p_word = fifo_q.pop_front();
            end
            if (f_valid && qualifies(f_word)) begin
                if (was_full) begin
                    exp_overflow = 1'b1;
                end else begin
                    fifo_q.push_back(f_word);
                end
            end
            f_valid = resp_valid;
            f_word  = resp_word;
        end
    end

    // ------------------------------------------------------------------
    // Output comparison
    // ------------------------------------------------------------------
    always @(negedge ap_clk) begin
        if (row_test != cur_test) begin
            if (cur_test != 0) begin
                report_test(cur_test);
            end
            cur_test = row_test;
            err_base = error_count;
        end
        if (!rst) begin
            check_field("overflow", 64'(overflow), 64'(exp_overflow));
            if (config_valid !== exp_valid) begin
                $display("test %0d: %s", cur_test, exp_valid ?
                         "config_valid missing where a record was due" :
                         "config_valid raised with no record due");
                error_count++;
            end else if (exp_valid) begin
                seen_cnt[cur_test]++;
                check_field("increment", 64'(config_out.increment), 64'(exp_rec.increment));
                check_field("decrement", 64'(config_out.decrement), 64'(exp_rec.decrement));
                check_field("mode_sequence", 64'(config_out.mode_sequence),
                            64'(exp_rec.mode_sequence));
                check_field("mode_buffer", 64'(config_out.mode_buffer),
                            64'(exp_rec.mode_buffer));
                check_field("mode_counter", 64'(config_out.mode_counter),
                            64'(exp_rec.mode_counter));
                check_field("index_start", 64'(config_out.index_start),
                            64'(exp_rec.index_start));
                check_field("index_end", 64'(config_out.index_end), 64'(exp_rec.index_end));
                check_field("stride", 64'(config_out.stride), 64'(exp_rec.stride));
                check_field("granularity", 64'(config_out.granularity),
                            64'(exp_rec.granularity));
                check_field("direction", 64'(config_out.direction), 64'(exp_rec.direction));
                check_field("array_pointer", config_out.array_pointer, exp_rec.array_pointer);
                check_field("array_size", 64'(config_out.array_size), 64'(exp_rec.array_size));
            end
        end
    end

endmodule

// ==== sim/tb_engine_config_loader.sv ====
/*
  Loader for engine slot 1, so the window is word indexes 8 to 15.
  Rows are applied on falling edges; the run is capped at rows plus 64 cycles.
*/
`timescale 1ns/1ps

module tb_engine_config_loader;

    import cfg_pkg::*;

    localparam int max_rows  = 192;
    localparam int num_tests = 5;

    // One stimulus row with its expectation
    typedef struct {
        logic          valid;
        buffer_class_e buffer_class;
        word_index_t   word_index;
        cfg_word_t     data;
        logic          drain;
        int            test;
        logic          expect_rec;
    } stim_row_t;

    stim_row_t      rows [max_rows];
    int             n_rows = 0;
    int             seed = 32'h1490f39b;
    int             cycles = 0;
    buffer_class_e  junk_cls [4] = '{class_data, class_other, class_engine_setup,
                                     class_cu_setup};
    int             junk_idx [4] = '{9, 10, 7, 16};

    logic           ap_clk;
    logic           rst;
    logic           resp_valid;
    setup_word_t    resp_word;
    logic           drain_en;
    logic           config_valid;
    engine_config_t config_out;
    logic           overflow;
    int             test_id;
    logic           expect_rec;
    int             error_count;

    engine_config_loader #(
        .engine_slot(1),
        .fifo_depth (16)
    ) i_engine_config_loader (
        .ap_clk      (ap_clk),
        .rst         (rst),
        .resp_valid  (resp_valid),
        .resp_word   (resp_word),
        .drain_en    (drain_en),
        .config_valid(config_valid),
        .config_out  (config_out),
        .overflow    (overflow)
    );

    config_checker #(
        .engine_slot(1),
        .fifo_depth (16)
    ) i_config_checker (
        .ap_clk      (ap_clk),
        .rst         (rst),
        .resp_valid  (resp_valid),
        .resp_word   (resp_word),
        .drain_en    (drain_en),
        .config_valid(config_valid),
        .config_out  (config_out),
        .overflow    (overflow),
        .test_id     (test_id),
        .expect_rec  (expect_rec),
        .error_count (error_count)
    );

    // ------------------------------------------------------------------
    // Table building
    // ------------------------------------------------------------------
    task automatic add_row(input logic v, input buffer_class_e cls, input int idx,
                           input logic drain, input int test, input logic exp);
        rows[n_rows].valid        = v;
        rows[n_rows].buffer_class = cls;
        rows[n_rows].word_index   = word_index_t'(idx);
        rows[n_rows].data         = $random(seed);
        rows[n_rows].drain        = drain;
        rows[n_rows].test         = test;
        rows[n_rows].expect_rec   = exp;
        n_rows++;
    endtask

    task automatic add_words(input buffer_class_e cls, input int first, input int count,
                             input logic drain, input int test);
        for (int i = 0; i < count; i++) begin
            add_row(1'b1, cls, first + i, drain, test, 1'b0);
        end
    endtask

    // Quiet rows whose first recs entries each announce one record
    task automatic add_idle(input int count, input logic drain, input int test,
                            input int recs);
        for (int i = 0; i < count; i++) begin
            add_row(1'b0, class_none, 0, drain, test, i < recs);
        end
    endtask

    initial begin
        ap_clk = 1'b0;
        forever #5 ap_clk = ~ap_clk;
    end

    // Watchdog
    always @(posedge ap_clk) begin
        cycles <= cycles + 1;
        if (cycles > n_rows + 64) begin
            $display("Timeout: run went past %0d cycles", n_rows + 64);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        rst        = 1'b1;
        resp_valid = 1'b0;
        resp_word  = '0;
        drain_en   = 1'b0;
        test_id    = 0;
        expect_rec = 1'b0;

        // Clean sequence
        add_words(class_engine_setup, 8, 8, 1'b1, 1);
        add_idle(12, 1'b1, 1, 1);
        // Foreign classes and out-of-window indexes mixed in
        add_row(1'b0, class_engine_setup, 8, 1'b1, 2, 1'b0);
        for (int i = 0; i < 8; i++) begin
            add_row(1'b1, class_cu_setup, 8 + i, 1'b1, 2, 1'b0);
            if (i % 2 == 0) begin
                add_row(1'b1, junk_cls[i / 2], junk_idx[i / 2], 1'b1, 2, 1'b0);
            end
        end
        add_idle(12, 1'b1, 2, 1);
        // Orphan words with no base word ahead of them
        add_words(class_cu_setup, 9, 7, 1'b1, 3);
        add_words(class_engine_setup, 8, 8, 1'b1, 3);
        add_idle(12, 1'b1, 3, 1);
        // Held back by drain_en
        add_words(class_engine_setup, 8, 8, 1'b0, 4);
        add_idle(8, 1'b0, 4, 0);
        add_idle(14, 1'b1, 4, 1);
        // 20 words into 16 entries
        add_words(class_engine_setup, 8, 8, 1'b0, 5);
        add_words(class_engine_setup, 8, 8, 1'b0, 5);
        add_words(class_engine_setup, 8, 4, 1'b0, 5);
        add_idle(4, 1'b0, 5, 0);
        add_idle(28, 1'b1, 5, 2);

        repeat (4) @(negedge ap_clk);
        rst = 1'b0;

        for (int r = 0; r < n_rows; r++) begin
            @(negedge ap_clk);
            resp_valid             = rows[r].valid;
            resp_word.buffer_class = rows[r].buffer_class;
            resp_word.word_index   = rows[r].word_index;
            resp_word.data         = rows[r].data;
            drain_en               = rows[r].drain;
            test_id                = rows[r].test;
            expect_rec             = rows[r].expect_rec;
        end
        @(negedge ap_clk);
        resp_valid = 1'b0;
        expect_rec = 1'b0;
        test_id    = 0;
        repeat (3) @(negedge ap_clk);

        $display("Summary: %0d tests, %0d errors", num_tests, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
logic/cfg_pkg.sv
logic/setup_filter.sv
logic/sync_fifo.sv
logic/config_assembler.sv
logic/engine_config_loader.sv
sim/config_checker.sv
sim/tb_engine_config_loader.sv

// ==== Makefile ====
TOP := tb_engine_config_loader

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
